//--- rtl/sad_pkg.sv
package sad_pkg;

    // sizes
    localparam int REF_SAMPLES = 8;                  // reference length, also the lane count
    localparam int SAMPLE_BITS = 8;
    localparam int SUM_BITS    = 16;                 // holds REF_SAMPLES full-scale differences
    localparam int IDX_BITS    = $clog2(REF_SAMPLES);

    // bytes seen through the register port
    localparam int REF_BYTES = REF_SAMPLES * SAMPLE_BITS / 8;
    localparam int SUM_BYTES = SUM_BITS / 8;

    // register map
    localparam logic [7:0] ADDR_REFERENCE   = 8'h60;
    localparam logic [7:0] ADDR_THRESHOLD   = 8'h61;
    localparam logic [7:0] ADDR_STATUS      = 8'h62;  // bit 0 triggered, any write clears
    localparam logic [7:0] ADDR_REF_SAMPLES = 8'h63;  // read only
    localparam logic [7:0] ADDR_MULTI_TRIG  = 8'h64;

    typedef logic [SAMPLE_BITS-1:0]             sample_t;
    typedef logic [SUM_BITS-1:0]                sum_t;
    typedef logic [IDX_BITS-1:0]                idx_t;
    typedef logic [REF_SAMPLES*SAMPLE_BITS-1:0] ref_vec_t;  // sample k at [k*SAMPLE_BITS +: SAMPLE_BITS]

    localparam idx_t IDX_LAST = idx_t'(REF_SAMPLES - 1);  // last position of a window

    typedef struct packed {
        ref_vec_t reference;
        sum_t     threshold;
        logic     multiple_triggers;
    } sad_cfg_t;

    typedef enum logic {
        ST_IDLE,
        ST_RUNNING
    } ctrl_state_t;

endpackage

//--- rtl/sad_regs.sv
`timescale 1ns/1ns

module sad_regs (
    input  logic              adc_sampleclk,
    input  logic              reset,
    input  logic [7:0]        reg_address,
    input  logic [7:0]        reg_bytecnt,
    input  logic [7:0]        reg_datai,
    input  logic              reg_read,
    input  logic              reg_write,
    input  logic              triggered,
    output logic [7:0]        reg_datao,
    output sad_pkg::sad_cfg_t cfg,
    output logic              status_clear
);

    logic ref_byte_ok;  // byte offset lands inside the reference
    logic thr_byte_ok;  // byte offset lands inside the threshold

    assign ref_byte_ok = (reg_bytecnt < sad_pkg::REF_BYTES);
    assign thr_byte_ok = (reg_bytecnt < sad_pkg::SUM_BYTES);

    // writes, one byte per access at reg_bytecnt
    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            cfg          <= '0;
            status_clear <= 1'b0;
        end else begin
            status_clear <= reg_write && (reg_address == sad_pkg::ADDR_STATUS);
            if (reg_write) begin
                case (reg_address)
                    sad_pkg::ADDR_REFERENCE: begin
                        if (ref_byte_ok) begin
                            cfg.reference[reg_bytecnt*8 +: 8] <= reg_datai;
                        end
                    end
                    sad_pkg::ADDR_THRESHOLD: begin
                        if (thr_byte_ok) begin
                            cfg.threshold[reg_bytecnt*8 +: 8] <= reg_datai;
                        end
                    end
                    sad_pkg::ADDR_MULTI_TRIG: begin
                        cfg.multiple_triggers <= reg_datai[0];
                    end
                    default: ;  // status handled above, size reg is read only
                endcase
            end
        end
    end

    // read mux
    always_comb begin
        reg_datao = 8'h00;
        if (reg_read) begin
            case (reg_address)
                sad_pkg::ADDR_REFERENCE: begin
                    if (ref_byte_ok) begin
                        reg_datao = cfg.reference[reg_bytecnt*8 +: 8];
                    end
                end
                sad_pkg::ADDR_THRESHOLD: begin
                    if (thr_byte_ok) begin
                        reg_datao = cfg.threshold[reg_bytecnt*8 +: 8];
                    end
                end
                sad_pkg::ADDR_STATUS: begin
                    reg_datao = {7'b0, triggered};
                end
                sad_pkg::ADDR_REF_SAMPLES: begin
                    reg_datao = 8'(sad_pkg::REF_SAMPLES);
                end
                sad_pkg::ADDR_MULTI_TRIG: begin
                    reg_datao = {7'b0, cfg.multiple_triggers};
                end
                default: begin
                    reg_datao = 8'h00;
                end
            endcase
        end
    end

endmodule

//--- rtl/sad_lane.sv
`timescale 1ns/1ns

// one phase of the SAD bank: sums one aligned window, then starts over
module sad_lane (
    input  logic             adc_sampleclk,
    input  logic             enable,
    input  sad_pkg::sample_t diff,
    input  sad_pkg::sum_t    threshold,
    output logic             hit
);

    sad_pkg::sum_t acc;       // partial sum of the current window
    sad_pkg::sum_t sum_next;  // sum including this cycle's difference
    sad_pkg::idx_t pos;       // position of diff within the window

    assign sum_next = acc + sad_pkg::sum_t'(diff);

    always_ff @(posedge adc_sampleclk) begin
        if (!enable) begin
            acc <= '0;
            pos <= '0;
            hit <= 1'b0;
        end else if (pos == sad_pkg::IDX_LAST) begin
            // window complete, test and restart
            hit <= (sum_next <= threshold);
            acc <= '0;
            pos <= '0;
        end else begin
            hit <= 1'b0;
            acc <= sum_next;
            pos <= pos + 1'b1;
        end
    end

endmodule

//--- rtl/sad_lanes.sv
`timescale 1ns/1ns

module sad_lanes (
    input  logic                             adc_sampleclk,
    input  logic                             running,
    input  sad_pkg::sample_t                 adc_datain,
    input  sad_pkg::sad_cfg_t                cfg,
    output logic [sad_pkg::REF_SAMPLES-1:0]  lane_hit
);

    logic [sad_pkg::REF_SAMPLES-2:0] start_sr;  // running, delayed by 1..N-1 cycles
    logic [sad_pkg::REF_SAMPLES-1:0] lane_go;   // lane j sees samples from index j on
    logic [sad_pkg::REF_SAMPLES-1:0] lane_en;   // lane_go aligned with the registered diff

    // stagger chain, empties as soon as running drops
    always_ff @(posedge adc_sampleclk) begin
        if (!running) begin
            start_sr <= '0;
        end else begin
            start_sr <= (start_sr << 1) | 1'b1;
        end
    end

    assign lane_go = {start_sr, 1'b1} & {sad_pkg::REF_SAMPLES{running}};

    always_ff @(posedge adc_sampleclk) begin
        lane_en <= lane_go;
    end

    for (genvar j = 0; j < sad_pkg::REF_SAMPLES; j++) begin : g_lane
        sad_pkg::idx_t    ref_idx;     // reference sample matching adc_datain
        sad_pkg::sample_t ref_sample;
        sad_pkg::sample_t diff;

        always_ff @(posedge adc_sampleclk) begin
            if (!lane_go[j] || ref_idx == sad_pkg::IDX_LAST) begin
                ref_idx <= '0;
            end else begin
                ref_idx <= ref_idx + 1'b1;
            end
        end

        assign ref_sample = cfg.reference[ref_idx*sad_pkg::SAMPLE_BITS +: sad_pkg::SAMPLE_BITS];

        // |sample - reference|, one cycle of latency
        always_ff @(posedge adc_sampleclk) begin
            diff <= (adc_datain > ref_sample) ? adc_datain - ref_sample
                                              : ref_sample - adc_datain;
        end

        sad_lane i_lane (
            .adc_sampleclk (adc_sampleclk),
            .enable        (lane_en[j] & running),  // clear the moment the run ends
            .diff          (diff),
            .threshold     (cfg.threshold),
            .hit           (lane_hit[j])
        );
    end

endmodule

//--- rtl/sad_trigger_ctrl.sv
`timescale 1ns/1ns

module sad_trigger_ctrl (
    input  logic                             adc_sampleclk,
    input  logic                             reset,
    input  logic                             arm,
    input  logic                             active,
    input  logic [sad_pkg::REF_SAMPLES-1:0]  lane_hit,
    input  sad_pkg::sad_cfg_t                cfg,
    input  logic                             status_clear,
    output logic                             running,
    output logic                             trigger,
    output logic                             triggered
);

    sad_pkg::ctrl_state_t state;
    sad_pkg::ctrl_state_t state_next;
    logic                 any_hit;  // some lane closed a matching window
    logic                 fire;     // raise trigger at the next edge

    assign any_hit = |lane_hit;
    assign running = (state == sad_pkg::ST_RUNNING);

    // hits only count while the run is still on
    assign fire = running && any_hit;

    always_comb begin
        state_next = state;
        case (state)
            sad_pkg::ST_IDLE: begin
                if (arm && active) begin
                    state_next = sad_pkg::ST_RUNNING;
                end
            end
            sad_pkg::ST_RUNNING: begin
                if (!active) begin
                    state_next = sad_pkg::ST_IDLE;
                end else if (fire && !cfg.multiple_triggers) begin
                    state_next = sad_pkg::ST_IDLE;  // single shot, done
                end
            end
            default: begin
                state_next = sad_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            state   <= sad_pkg::ST_IDLE;
            trigger <= 1'b0;
        end else begin
            state   <= state_next;
            trigger <= fire;
        end
    end

    // sticky status, the host write wins over a new trigger
    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            triggered <= 1'b0;
        end else if (status_clear) begin
            triggered <= 1'b0;
        end else if (trigger) begin
            triggered <= 1'b1;
        end
    end

endmodule

//--- rtl/sad_trigger.sv
`timescale 1ns/1ns

module sad_trigger (
    input  logic             adc_sampleclk,
    input  logic             reset,
    input  sad_pkg::sample_t adc_datain,
    input  logic             arm,
    input  logic             active,
    input  logic [7:0]       reg_address,
    input  logic [7:0]       reg_bytecnt,
    input  logic [7:0]       reg_datai,
    output logic [7:0]       reg_datao,
    input  logic             reg_read,
    input  logic             reg_write,
    output logic             trigger
);

    sad_pkg::sad_cfg_t               cfg;
    logic                            status_clear;
    logic                            running;
    logic                            triggered;
    logic [sad_pkg::REF_SAMPLES-1:0] lane_hit;

    sad_regs i_regs (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .reg_address   (reg_address),
        .reg_bytecnt   (reg_bytecnt),
        .reg_datai     (reg_datai),
        .reg_read      (reg_read),
        .reg_write     (reg_write),
        .triggered     (triggered),
        .reg_datao     (reg_datao),
        .cfg           (cfg),
        .status_clear  (status_clear)
    );

    sad_lanes i_lanes (
        .adc_sampleclk (adc_sampleclk),
        .running       (running),
        .adc_datain    (adc_datain),
        .cfg           (cfg),
        .lane_hit      (lane_hit)
    );

    sad_trigger_ctrl i_ctrl (
        .adc_sampleclk (adc_sampleclk),
        .reset         (reset),
        .arm           (arm),
        .active        (active),
        .lane_hit      (lane_hit),
        .cfg           (cfg),
        .status_clear  (status_clear),
        .running       (running),
        .trigger       (trigger),
        .triggered     (triggered)
    );

endmodule

//--- verification/sad_tb.sv
`timescale 1ns/1ns

module sad_tb;

    localparam int N    = sad_pkg::REF_SAMPLES;
    localparam int MAXS = 64;  // longest run in samples
    localparam int TAIL = 6;   // cycles watched after the last sample

    // reset, register reads, six config loads, run sample cycles, status accesses
    localparam int CFG_CYCLES  = 2 * (N + 3);
    localparam int RUN_CYCLES  = (40 + 30 + 30 + 56 + 17) + 5 * (TAIL + 1);
    localparam int TEST_CYCLES = 8 + 2 * (N + 5) + 6 * CFG_CYCLES + RUN_CYCLES + 10;
    localparam int MAX_CYCLES  = 2 * TEST_CYCLES;

    logic             adc_sampleclk = 1'b0;
    logic             reset;
    sad_pkg::sample_t adc_datain;
    logic             arm;
    logic             active;
    logic [7:0]       reg_address;
    logic [7:0]       reg_bytecnt;
    logic [7:0]       reg_datai;
    logic [7:0]       reg_datao;
    logic             reg_read;
    logic             reg_write;
    logic             trigger;

    sad_pkg::sample_t ref_tb [N];         // model copy of the reference
    sad_pkg::sum_t    thr_tb;
    logic             multi_tb;
    sad_pkg::sample_t run_samples [MAXS];
    logic             exp_trig [MAXS + TAIL];
    int               errors = 0;
    int               checks = 0;
    int               cycles = 0;

    sad_trigger i_dut (.*);

    always #10 adc_sampleclk = ~adc_sampleclk;

    always @(posedge adc_sampleclk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not end within %0d cycles", MAX_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %0t %s: got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [7:0] cnt, input logic [7:0] data);
        @(negedge adc_sampleclk);
        reg_address = addr;
        reg_bytecnt = cnt;
        reg_datai   = data;
        reg_write   = 1'b1;
        @(negedge adc_sampleclk);
        reg_write = 1'b0;
    endtask

    task automatic read_check(input string name, input logic [7:0] addr, input logic [7:0] cnt,
                              input logic [7:0] exp);
        @(negedge adc_sampleclk);
        reg_address = addr;
        reg_bytecnt = cnt;
        reg_read    = 1'b1;
        #5;  // read mux is combinational, sample mid low phase
        check_val(name, reg_datao, exp);
        @(negedge adc_sampleclk);
        reg_read = 1'b0;
    endtask

    task automatic new_reference();
        for (int i = 0; i < N; i++) begin
            ref_tb[i] = sad_pkg::sample_t'($urandom_range(255, 0));
        end
    endtask

    task automatic load_config(input sad_pkg::sum_t thr, input logic multi);
        thr_tb   = thr;
        multi_tb = multi;
        for (int i = 0; i < N; i++) begin
            write_reg(sad_pkg::ADDR_REFERENCE, 8'(i), ref_tb[i]);
        end
        write_reg(sad_pkg::ADDR_THRESHOLD, 8'd0, thr[7:0]);
        write_reg(sad_pkg::ADDR_THRESHOLD, 8'd1, thr[15:8]);
        write_reg(sad_pkg::ADDR_MULTI_TRIG, 8'd0, {7'b0, multi});
    endtask

    task automatic fill_random(input int len);
        for (int k = 0; k < len; k++) begin
            run_samples[k] = sad_pkg::sample_t'($urandom_range(255, 0));
        end
    endtask

    task automatic place_ref(input int start);
        for (int i = 0; i < N; i++) begin
            run_samples[start + i] = ref_tb[i];
        end
    endtask

    // SAD of the window ending at sample t
    function automatic int window_sad(input int t);
        int sum = 0;
        int d;
        for (int i = 0; i < N; i++) begin
            d = int'(run_samples[t - N + 1 + i]) - int'(ref_tb[i]);
            sum += (d < 0) ? -d : d;
        end
        return sum;
    endfunction

    // arm, feed samples 0..last, active drops with sample last
    task automatic run_check(input int last);
        int t;
        bit matched = 0;
        for (int k = 0; k < last + TAIL; k++) begin
            t = k - 3;  // window whose trigger shows at observation k
            exp_trig[k] = 1'b0;
            if (t >= N - 1 && t + 2 <= last && !(matched && !multi_tb)) begin
                if (window_sad(t) <= int'(thr_tb)) begin
                    exp_trig[k] = 1'b1;
                    matched = 1;
                end
            end
        end
        @(negedge adc_sampleclk);
        arm    = 1'b1;
        active = 1'b1;
        for (int k = 0; k < last + TAIL; k++) begin
            @(negedge adc_sampleclk);
            check_val("trigger", trigger, exp_trig[k]);
            arm        = 1'b0;
            active     = (k < last);
            adc_datain = (k <= last) ? run_samples[k] : sad_pkg::sample_t'($urandom_range(255, 0));
        end
    endtask

    task automatic register_round_trip();
        new_reference();
        load_config(sad_pkg::sum_t'($urandom_range(16'hffff, 0)), 1'b1);
        for (int i = 0; i < N; i++) begin
            read_check($sformatf("reference[%0d]", i), sad_pkg::ADDR_REFERENCE, 8'(i), ref_tb[i]);
        end
        read_check("threshold[7:0]", sad_pkg::ADDR_THRESHOLD, 8'd0, thr_tb[7:0]);
        read_check("threshold[15:8]", sad_pkg::ADDR_THRESHOLD, 8'd1, thr_tb[15:8]);
        read_check("multi_trig", sad_pkg::ADDR_MULTI_TRIG, 8'd0, {7'b0, multi_tb});
        read_check("ref_samples", sad_pkg::ADDR_REF_SAMPLES, 8'd0, 8'(N));
        read_check("unknown reg", 8'h10, 8'd0, 8'h00);
    endtask

    task automatic exact_match_single();
        new_reference();
        load_config('0, 1'b0);
        fill_random(41);
        place_ref(9);
        place_ref(25);  // second copy must be ignored
        run_check(40);
    endtask

    task automatic near_match_threshold();
        int off;
        int v;
        int sad;
        new_reference();
        fill_random(31);
        for (int i = 0; i < N; i++) begin
            off = $urandom_range(3, (i == 0) ? 1 : 0);  // at least one nonzero offset
            v   = int'(ref_tb[i]) + off;
            run_samples[12 + i] = sad_pkg::sample_t'((v > 255) ? int'(ref_tb[i]) - off : v);
        end
        sad = window_sad(12 + N - 1);
        load_config(sad_pkg::sum_t'(sad), 1'b0);      // at the SAD, trigger
        run_check(30);
        load_config(sad_pkg::sum_t'(sad - 1), 1'b0);  // just below, no trigger
        run_check(30);
    endtask

    task automatic multiple_trigger_runs();
        new_reference();
        load_config('0, 1'b1);
        fill_random(57);
        place_ref(2);   // lane 2
        place_ref(13);  // lane 5
        place_ref(27);  // lane 3
        place_ref(40);  // lane 0
        run_check(56);
    endtask

    task automatic status_and_stop();
        read_check("triggered", sad_pkg::ADDR_STATUS, 8'd0, 8'h01);
        write_reg(sad_pkg::ADDR_STATUS, 8'd0, 8'h00);
        read_check("triggered", sad_pkg::ADDR_STATUS, 8'd0, 8'h00);
        new_reference();
        load_config('0, 1'b1);
        fill_random(18);
        place_ref(0);
        place_ref(10);  // completes as active drops
        run_check(17);
    endtask

    initial begin
        void'($urandom(86));
        reset       = 1'b1;
        adc_datain  = '0;
        arm         = 1'b0;
        active      = 1'b0;
        reg_address = '0;
        reg_bytecnt = '0;
        reg_datai   = '0;
        reg_read    = 1'b0;
        reg_write   = 1'b0;
        repeat (8) @(negedge adc_sampleclk);
        reset = 1'b0;

        register_round_trip();
        exact_match_single();
        near_match_threshold();
        multiple_trigger_runs();
        status_and_stop();

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
rtl/sad_pkg.sv
rtl/sad_regs.sv
rtl/sad_lane.sv
rtl/sad_lanes.sv
rtl/sad_trigger_ctrl.sv
rtl/sad_trigger.sv
verification/sad_tb.sv

//--- Bender.yml
package:
  name: sad_trigger

sources:
  - files:
      - rtl/sad_pkg.sv
      - rtl/sad_regs.sv
      - rtl/sad_lane.sv
      - rtl/sad_lanes.sv
      - rtl/sad_trigger_ctrl.sv
      - rtl/sad_trigger.sv
  - target: test
    files:
      - verification/sad_tb.sv
